// ==== soc_consts.svh ====
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// bus address width
`define SOC_ADDR_W 16

// peripheral regions, 16 bytes each
`define TIMER_BASE 16'hFFD0
`define PRNG_BASE 16'hFFE0
`define LEDS_BASE 16'hFFF0

// on-chip ram, 4 KiB
`define RAM_ADDR_BITS 12

// timer register offsets
`define TIMER_REG_RELOAD_LO 4'd0
`define TIMER_REG_RELOAD_HI 4'd1
`define TIMER_REG_CTRL 4'd2
`define TIMER_REG_STATUS 4'd3

// prng register offsets
`define PRNG_REG_SEED_LO 4'd0
`define PRNG_REG_SEED_HI 4'd1
`define PRNG_REG_NEXT 4'd2

// galois feedback taps for x^16 + x^14 + x^13 + x^11 + 1
`define PRNG_TAPS 16'hB400

`define RESET_HOLD_CYCLES 16

`endif

// ==== soc_pkg.sv ====
`include "soc_consts.svh"

package soc_pkg;

    // one byte on the data bus
    typedef logic [7:0] bus_data_t;

    typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;

    // which slave owns the current address
    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_TIMER,
        SEL_PRNG,
        SEL_LEDS
    } slave_sel_t;

endpackage

// ==== reset_stretch.sv ====
`timescale 1ns/100ps

`include "soc_consts.svh"

module reset_stretch #(
    parameter int HOLD_CYCLES = `RESET_HOLD_CYCLES
) (
    input  logic clk,
    input  logic reset_i,
    output logic soc_reset_o
);

    localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

    logic [CNT_W-1:0] hold_cnt;

    // reload while the external reset is held, then count down
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hold_cnt <= CNT_W'(HOLD_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign soc_reset_o = reset_i || (hold_cnt != '0);

endmodule

// ==== bus_decoder.sv ====
`timescale 1ns/100ps

`include "soc_consts.svh"

module bus_decoder (
    input  soc_pkg::bus_addr_t bus_adr_i,
    input  logic               bus_stb_i,
    input  soc_pkg::bus_data_t ram_dat_i,
    input  soc_pkg::bus_data_t timer_dat_i,
    input  soc_pkg::bus_data_t prng_dat_i,
    input  soc_pkg::bus_data_t leds_dat_i,
    input  logic               ram_ack_i,
    input  logic               timer_ack_i,
    input  logic               prng_ack_i,
    input  logic               leds_ack_i,
    output logic               ram_stb_o,
    output logic               timer_stb_o,
    output logic               prng_stb_o,
    output logic               leds_stb_o,
    output soc_pkg::bus_data_t bus_dat_o,
    output logic               bus_ack_o
);

    localparam soc_pkg::bus_addr_t TIMER_BASE_A = `TIMER_BASE;
    localparam soc_pkg::bus_addr_t PRNG_BASE_A = `PRNG_BASE;
    localparam soc_pkg::bus_addr_t LEDS_BASE_A = `LEDS_BASE;

    soc_pkg::slave_sel_t slave_sel;
    logic [`SOC_ADDR_W-5:0] region;

    // regions are picked by everything above the low nibble
    assign region = bus_adr_i[`SOC_ADDR_W-1:4];

    always_comb begin
        // unmapped addresses fall through to ram
        slave_sel = soc_pkg::SEL_RAM;
        if (region == TIMER_BASE_A[`SOC_ADDR_W-1:4]) begin
            slave_sel = soc_pkg::SEL_TIMER;
        end else if (region == PRNG_BASE_A[`SOC_ADDR_W-1:4]) begin
            slave_sel = soc_pkg::SEL_PRNG;
        end else if (region == LEDS_BASE_A[`SOC_ADDR_W-1:4]) begin
            slave_sel = soc_pkg::SEL_LEDS;
        end
    end

    assign ram_stb_o = bus_stb_i && (slave_sel == soc_pkg::SEL_RAM);
    assign timer_stb_o = bus_stb_i && (slave_sel == soc_pkg::SEL_TIMER);
    assign prng_stb_o = bus_stb_i && (slave_sel == soc_pkg::SEL_PRNG);
    assign leds_stb_o = bus_stb_i && (slave_sel == soc_pkg::SEL_LEDS);

    // response mux
    always_comb begin
        case (slave_sel)
            soc_pkg::SEL_TIMER: begin
                bus_dat_o = timer_dat_i;
                bus_ack_o = timer_ack_i;
            end
            soc_pkg::SEL_PRNG: begin
                bus_dat_o = prng_dat_i;
                bus_ack_o = prng_ack_i;
            end
            soc_pkg::SEL_LEDS: begin
                bus_dat_o = leds_dat_i;
                bus_ack_o = leds_ack_i;
            end
            default: begin
                bus_dat_o = ram_dat_i;
                bus_ack_o = ram_ack_i;
            end
        endcase
    end

endmodule

// ==== ram_wb8.sv ====
`timescale 1ns/100ps

`include "soc_consts.svh"

module ram_wb8 #(
    parameter int ADDR_BITS = `RAM_ADDR_BITS
) (
    input  logic                 clk,
    input  logic                 soc_reset_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  logic [ADDR_BITS-1:0] adr_i,
    input  soc_pkg::bus_data_t   dat_i,
    output soc_pkg::bus_data_t   dat_o,
    output logic                 ack_o
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    soc_pkg::bus_data_t mem [DEPTH];

    logic access;

    // new strobe, not yet answered
    assign access = stb_i && !ack_o && !soc_reset_i;

    always_ff @(posedge clk) begin
        if (soc_reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i && !ack_o;
        end
    end

    // single port, read-before-write
    always_ff @(posedge clk) begin
        if (access) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
        end
    end

endmodule

// ==== timer_wb8.sv ====
`timescale 1ns/100ps

`include "soc_consts.svh"

module timer_wb8 (
    input  logic               clk,
    input  logic               soc_reset_i,
    input  logic               stb_i,
    input  logic               we_i,
    input  logic [3:0]         adr_i,
    input  soc_pkg::bus_data_t dat_i,
    output soc_pkg::bus_data_t dat_o,
    output logic               ack_o,
    output logic               irq_o
);

    logic [15:0] reload_q;
    logic [15:0] count_q;
    // bit 0 run, bit 1 irq enable
    logic [1:0] ctrl_q;
    logic expired_q;

    logic access;
    logic wr_en;
    soc_pkg::bus_data_t rd_data;

    assign access = stb_i && !ack_o && !soc_reset_i;
    assign wr_en = access && we_i;

    always_ff @(posedge clk) begin
        if (wr_en && adr_i == `TIMER_REG_RELOAD_LO) begin
            reload_q[7:0] <= dat_i;
        end
        if (wr_en && adr_i == `TIMER_REG_RELOAD_HI) begin
            reload_q[15:8] <= dat_i;
        end
    end

    always_ff @(posedge clk) begin
        if (soc_reset_i) begin
            ack_o <= 1'b0;
            count_q <= '0;
            ctrl_q <= '0;
            expired_q <= 1'b0;
        end else begin
            ack_o <= stb_i && !ack_o;
            if (ctrl_q[0]) begin
                // reload on the cycle after zero is reached
                if (count_q == '0) begin
                    expired_q <= 1'b1;
                    count_q <= reload_q;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
            if (wr_en && adr_i == `TIMER_REG_STATUS && dat_i[0]) begin
                expired_q <= 1'b0;
            end
            if (wr_en && adr_i == `TIMER_REG_CTRL) begin
                ctrl_q <= dat_i[1:0];
                if (dat_i[0]) begin
                    count_q <= reload_q;
                end
            end
        end
    end

    always_comb begin
        case (adr_i)
            `TIMER_REG_RELOAD_LO: rd_data = reload_q[7:0];
            `TIMER_REG_RELOAD_HI: rd_data = reload_q[15:8];
            `TIMER_REG_CTRL:      rd_data = {6'b0, ctrl_q};
            `TIMER_REG_STATUS:    rd_data = {7'b0, expired_q};
            default:              rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_o <= rd_data;
        end
    end

    assign irq_o = expired_q && ctrl_q[1];

endmodule

// ==== prng_wb8.sv ====
`timescale 1ns/100ps

`include "soc_consts.svh"

module prng_wb8 (
    input  logic               clk,
    input  logic               soc_reset_i,
    input  logic               stb_i,
    input  logic               we_i,
    input  logic [3:0]         adr_i,
    input  soc_pkg::bus_data_t dat_i,
    output soc_pkg::bus_data_t dat_o,
    output logic               ack_o
);

    logic [15:0] state_q;
    logic access;
    logic wr_en;
    logic rd_en;
    soc_pkg::bus_data_t rd_data;

    // one galois step, shift right and fold in the taps
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] shifted;
        shifted = {1'b0, s[15:1]};
        return s[0] ? (shifted ^ `PRNG_TAPS) : shifted;
    endfunction

    // all-zero would lock up the lfsr
    function automatic logic [15:0] seed_fix(input logic [15:0] s);
        return (s == '0) ? 16'h0001 : s;
    endfunction

    assign access = stb_i && !ack_o && !soc_reset_i;
    assign wr_en = access && we_i;
    assign rd_en = access && !we_i;

    always_ff @(posedge clk) begin
        if (soc_reset_i) begin
            ack_o <= 1'b0;
            state_q <= 16'h0001;
        end else begin
            ack_o <= stb_i && !ack_o;
            if (wr_en && adr_i == `PRNG_REG_SEED_LO) begin
                state_q <= seed_fix({state_q[15:8], dat_i});
            end else if (wr_en && adr_i == `PRNG_REG_SEED_HI) begin
                state_q <= seed_fix({dat_i, state_q[7:0]});
            end else if (rd_en && adr_i == `PRNG_REG_NEXT) begin
                state_q <= lfsr_step(state_q);
            end
        end
    end

    always_comb begin
        case (adr_i)
            `PRNG_REG_SEED_LO: rd_data = state_q[7:0];
            `PRNG_REG_SEED_HI: rd_data = state_q[15:8];
            `PRNG_REG_NEXT:    rd_data = state_q[7:0];
            default:           rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            dat_o <= rd_data;
        end
    end

endmodule

// ==== leds_wb8.sv ====
`timescale 1ns/100ps

module leds_wb8 (
    input  logic               clk,
    input  logic               soc_reset_i,
    input  logic               stb_i,
    input  logic               we_i,
    input  soc_pkg::bus_data_t dat_i,
    output soc_pkg::bus_data_t dat_o,
    output logic               ack_o,
    output soc_pkg::bus_data_t leds_o
);

    logic access;

    assign access = stb_i && !ack_o && !soc_reset_i;

    always_ff @(posedge clk) begin
        if (soc_reset_i) begin
            ack_o <= 1'b0;
            leds_o <= '0;
        end else begin
            ack_o <= stb_i && !ack_o;
            if (access && we_i) begin
                leds_o <= dat_i;
            end
        end
    end

    // read back the current pattern
    always_ff @(posedge clk) begin
        if (access && !we_i) begin
            dat_o <= leds_o;
        end
    end

endmodule

// ==== soc_top.sv ====
`timescale 1ns/100ps

`include "soc_consts.svh"

module soc_top (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               bus_stb_i,
    input  logic               bus_we_i,
    input  soc_pkg::bus_addr_t bus_adr_i,
    input  soc_pkg::bus_data_t bus_dat_i,
    output soc_pkg::bus_data_t bus_dat_o,
    output logic               bus_ack_o,
    output soc_pkg::bus_data_t leds_o,
    output logic               timer_irq_o
);

    logic soc_reset;

    logic ram_stb;
    logic timer_stb;
    logic prng_stb;
    logic leds_stb;

    soc_pkg::bus_data_t ram_dat;
    soc_pkg::bus_data_t timer_dat;
    soc_pkg::bus_data_t prng_dat;
    soc_pkg::bus_data_t leds_dat;

    logic ram_ack;
    logic timer_ack;
    logic prng_ack;
    logic leds_ack;

    reset_stretch u_reset_stretch (
        .clk         (clk),
        .reset_i     (reset_i),
        .soc_reset_o (soc_reset)
    );

    bus_decoder u_bus_decoder (
        .bus_adr_i   (bus_adr_i),
        .bus_stb_i   (bus_stb_i),
        .ram_dat_i   (ram_dat),
        .timer_dat_i (timer_dat),
        .prng_dat_i  (prng_dat),
        .leds_dat_i  (leds_dat),
        .ram_ack_i   (ram_ack),
        .timer_ack_i (timer_ack),
        .prng_ack_i  (prng_ack),
        .leds_ack_i  (leds_ack),
        .ram_stb_o   (ram_stb),
        .timer_stb_o (timer_stb),
        .prng_stb_o  (prng_stb),
        .leds_stb_o  (leds_stb),
        .bus_dat_o   (bus_dat_o),
        .bus_ack_o   (bus_ack_o)
    );

    // ram aliases every 4 KiB
    ram_wb8 u_ram (
        .clk         (clk),
        .soc_reset_i (soc_reset),
        .stb_i       (ram_stb),
        .we_i        (bus_we_i),
        .adr_i       (bus_adr_i[`RAM_ADDR_BITS-1:0]),
        .dat_i       (bus_dat_i),
        .dat_o       (ram_dat),
        .ack_o       (ram_ack)
    );

    timer_wb8 u_timer (
        .clk         (clk),
        .soc_reset_i (soc_reset),
        .stb_i       (timer_stb),
        .we_i        (bus_we_i),
        .adr_i       (bus_adr_i[3:0]),
        .dat_i       (bus_dat_i),
        .dat_o       (timer_dat),
        .ack_o       (timer_ack),
        .irq_o       (timer_irq_o)
    );

    prng_wb8 u_prng (
        .clk         (clk),
        .soc_reset_i (soc_reset),
        .stb_i       (prng_stb),
        .we_i        (bus_we_i),
        .adr_i       (bus_adr_i[3:0]),
        .dat_i       (bus_dat_i),
        .dat_o       (prng_dat),
        .ack_o       (prng_ack)
    );

    leds_wb8 u_leds (
        .clk         (clk),
        .soc_reset_i (soc_reset),
        .stb_i       (leds_stb),
        .we_i        (bus_we_i),
        .dat_i       (bus_dat_i),
        .dat_o       (leds_dat),
        .ack_o       (leds_ack),
        .leds_o      (leds_o)
    );

endmodule

// ==== tb_soc.sv ====
`timescale 1ns/100ps

`include "soc_consts.svh"

module tb_soc;

    localparam int HALF_PERIOD = 20;
    localparam int DRIVE_DLY = 2;
    // the directed tests take well under half of this
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic reset_i;
    logic bus_stb_i;
    logic bus_we_i;
    soc_pkg::bus_addr_t bus_adr_i;
    soc_pkg::bus_data_t bus_dat_i;
    soc_pkg::bus_data_t bus_dat_o;
    logic bus_ack_o;
    soc_pkg::bus_data_t leds_o;
    logic timer_irq_o;

    int cycle_cnt = 0;
    int err_cnt = 0;
    int test_cnt = 0;
    int test_fail_cnt = 0;

    // expected ram contents by aliased address
    soc_pkg::bus_data_t ram_model [2**`RAM_ADDR_BITS];

    soc_top u_dut (
        .clk         (clk),
        .reset_i     (reset_i),
        .bus_stb_i   (bus_stb_i),
        .bus_we_i    (bus_we_i),
        .bus_adr_i   (bus_adr_i),
        .bus_dat_i   (bus_dat_i),
        .bus_dat_o   (bus_dat_o),
        .bus_ack_o   (bus_ack_o),
        .leds_o      (leds_o),
        .timer_irq_o (timer_irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic expect_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
        assert (got === exp) else begin
            $display("FAIL %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // address map from the master's side
    function automatic soc_pkg::slave_sel_t slave_of_addr(input soc_pkg::bus_addr_t adr);
        case (adr & 16'hFFF0)
            `TIMER_BASE: return soc_pkg::SEL_TIMER;
            `PRNG_BASE:  return soc_pkg::SEL_PRNG;
            `LEDS_BASE:  return soc_pkg::SEL_LEDS;
            default:     return soc_pkg::SEL_RAM;
        endcase
    endfunction

    // one master transaction that counts the edges up to the acknowledge
    task automatic bus_cycle(input logic we, input soc_pkg::bus_addr_t adr,
                             input soc_pkg::bus_data_t wdat,
                             output soc_pkg::bus_data_t rdat, output int cycles);
        @(posedge clk);
        #DRIVE_DLY;
        bus_adr_i = adr;
        bus_we_i = we;
        bus_dat_i = wdat;
        bus_stb_i = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end while (!bus_ack_o);
        rdat = bus_dat_o;
        bus_stb_i = 1'b0;
        bus_we_i = 1'b0;
    endtask

    task automatic bus_write(input soc_pkg::bus_addr_t adr, input soc_pkg::bus_data_t wdat);
        soc_pkg::bus_data_t ignored;
        int cycles;
        bus_cycle(1'b1, adr, wdat, ignored, cycles);
        expect_eq(16'(cycles), 16'd1, $sformatf("write latency at 0x%h", adr));
    endtask

    task automatic bus_read(input soc_pkg::bus_addr_t adr, output soc_pkg::bus_data_t rdat);
        int cycles;
        bus_cycle(1'b0, adr, 8'h00, rdat, cycles);
        expect_eq(16'(cycles), 16'd1, $sformatf("read latency at 0x%h", adr));
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            test_fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_reset();
        int errs;
        int cycles;
        soc_pkg::bus_data_t rdat;
        errs = err_cnt;
        expect_eq(16'(leds_o), 16'h0, "leds_o after reset");
        expect_eq(16'(timer_irq_o), 16'h0, "timer_irq_o after reset");
        // strobe rises one cycle after reset_i falls and waits out the stretch
        bus_cycle(1'b0, `LEDS_BASE, 8'h00, rdat, cycles);
        expect_eq(16'(cycles), 16'(`RESET_HOLD_CYCLES),
                  "acknowledge latency of a strobe inside the stretched reset");
        expect_eq(16'(rdat), 16'h0, "leds read after reset");
        repeat (2) @(posedge clk);
        bus_read(`LEDS_BASE, rdat);
        report_test("reset", errs);
    endtask

    task automatic test_ram();
        int errs;
        soc_pkg::bus_addr_t addrs [32];
        soc_pkg::bus_addr_t adr;
        soc_pkg::bus_data_t wdat;
        soc_pkg::bus_data_t rdat;
        errs = err_cnt;
        for (int i = 0; i < 32; i++) begin
            adr = soc_pkg::bus_addr_t'($urandom);
            // second half hits earlier cells through other upper bits
            if (i >= 16) begin
                adr[11:0] = addrs[i-16][11:0];
                adr[15:12] = addrs[i-16][15:12] ^ 4'h8;
            end
            if (slave_of_addr(adr) != soc_pkg::SEL_RAM) begin
                adr[15:4] = 12'hFFC;
            end
            wdat = soc_pkg::bus_data_t'($urandom);
            addrs[i] = adr;
            ram_model[adr[`RAM_ADDR_BITS-1:0]] = wdat;
            bus_write(adr, wdat);
        end
        for (int i = 0; i < 32; i++) begin
            bus_read(addrs[i], rdat);
            expect_eq(16'(rdat), 16'(ram_model[addrs[i][`RAM_ADDR_BITS-1:0]]),
                      $sformatf("ram read at 0x%h", addrs[i]));
        end
        report_test("ram", errs);
    endtask

    task automatic test_leds();
        int errs;
        soc_pkg::bus_data_t rdat;
        errs = err_cnt;
        bus_write(`LEDS_BASE, 8'hA5);
        expect_eq(16'(leds_o), 16'hA5, "leds_o after write");
        bus_read(`LEDS_BASE, rdat);
        expect_eq(16'(rdat), 16'hA5, "leds read back");
        bus_write(`PRNG_BASE, 8'h3C);
        expect_eq(16'(leds_o), 16'hA5, "leds_o after a prng write");
        report_test("leds", errs);
    endtask

    task automatic test_prng();
        int errs;
        logic [15:0] model;
        logic lsb;
        soc_pkg::bus_data_t rdat;
        errs = err_cnt;
        bus_write(`PRNG_BASE + `PRNG_REG_SEED_LO, 8'h34);
        bus_write(`PRNG_BASE + `PRNG_REG_SEED_HI, 8'h12);
        model = 16'h1234;
        for (int i = 0; i < 8; i++) begin
            bus_read(`PRNG_BASE + `PRNG_REG_NEXT, rdat);
            expect_eq(16'(rdat), 16'(model[7:0]), $sformatf("prng output %0d", i));
            lsb = model[0];
            model = model >> 1;
            if (lsb) begin
                model = model ^ `PRNG_TAPS;
            end
        end
        // zero seed must come back as 1
        bus_write(`PRNG_BASE + `PRNG_REG_SEED_LO, 8'h00);
        bus_write(`PRNG_BASE + `PRNG_REG_SEED_HI, 8'h00);
        bus_read(`PRNG_BASE + `PRNG_REG_SEED_LO, rdat);
        expect_eq(16'(rdat), 16'h01, "prng low byte after zero seed");
        bus_read(`PRNG_BASE + `PRNG_REG_SEED_HI, rdat);
        expect_eq(16'(rdat), 16'h00, "prng high byte after zero seed");
        report_test("prng", errs);
    endtask

    task automatic test_timer();
        int errs;
        int waited;
        logic irq_seen;
        soc_pkg::bus_data_t rdat;
        errs = err_cnt;
        bus_write(`TIMER_BASE + `TIMER_REG_RELOAD_LO, 8'd10);
        bus_write(`TIMER_BASE + `TIMER_REG_RELOAD_HI, 8'd0);
        bus_write(`TIMER_BASE + `TIMER_REG_CTRL, 8'h03);
        waited = 0;
        while (!timer_irq_o && waited < 20) begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end
        expect_eq(16'(waited), 16'd11, "cycles from control write to timer_irq_o");
        bus_read(`TIMER_BASE + `TIMER_REG_STATUS, rdat);
        expect_eq(16'(rdat), 16'h01, "timer status after expiry");
        bus_write(`TIMER_BASE + `TIMER_REG_STATUS, 8'h01);
        expect_eq(16'(timer_irq_o), 16'h0, "timer_irq_o after status clear");
        bus_write(`TIMER_BASE + `TIMER_REG_CTRL, 8'h00);
        // run with the interrupt masked
        bus_write(`TIMER_BASE + `TIMER_REG_CTRL, 8'h01);
        irq_seen = 1'b0;
        repeat (14) begin
            @(posedge clk);
            #DRIVE_DLY;
            irq_seen = irq_seen | timer_irq_o;
        end
        expect_eq(16'(irq_seen), 16'h0, "timer_irq_o with the interrupt masked");
        bus_read(`TIMER_BASE + `TIMER_REG_STATUS, rdat);
        expect_eq(16'(rdat), 16'h01, "timer status with the interrupt masked");
        bus_write(`TIMER_BASE + `TIMER_REG_CTRL, 8'h00);
        report_test("timer", errs);
    endtask

    initial begin
        void'($urandom(32'ha0d2cb63));
        reset_i = 1'b1;
        bus_stb_i = 1'b0;
        bus_we_i = 1'b0;
        bus_adr_i = '0;
        bus_dat_i = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        reset_i = 1'b0;
        test_reset();
        test_ram();
        test_leds();
        test_prng();
        test_timer();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 test_cnt, test_fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
soc_pkg.sv
reset_stretch.sv
bus_decoder.sv
ram_wb8.sv
timer_wb8.sv
prng_wb8.sv
leds_wb8.sv
soc_top.sv
tb_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the soc testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_soc -f files.f -o sim_soc

./obj_dir/sim_soc 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run_sim: testbench reported failure"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "run_sim: simulation ended without a result"
    exit 1
fi
echo "run_sim: passed"
